// ==== hdl/aes_defs.svh ====
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// Block and key width for AES-128
`define AES_BLOCK_W 128

`define AES_WORD_W 32   // One key word or state column

`define AES_NR 10        // Rounds for a 128-bit key

`define AES_RND_W 4      // Holds round numbers 0 to 10

`endif

// ==== hdl/aes_data_pkg.sv ====
`include "aes_defs.svh"

package aes_data_pkg;

    // Full state or cipher key, byte 0 in the top bits
    typedef logic [`AES_BLOCK_W-1:0] block_t;

    // Key word or one state column
    typedef logic [`AES_WORD_W-1:0] word_t;

    typedef logic [7:0] byte_t;   // GF(2^8) element

endpackage

// ==== hdl/aes_ctrl_pkg.sv ====
package aes_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'b00,  // Waiting for a strobe
        ST_K10_CALC = 2'b01,  // Forward key expansion up to K10
        ST_DECRYPT  = 2'b10   // One inverse round per cycle
    } fsm_state_t;

    typedef enum logic [1:0] {
        KX_HOLD    = 2'b00,
        KX_LOAD    = 2'b01,
        KX_FORWARD = 2'b10,
        KX_REVERSE = 2'b11
    } kx_op_t;

    typedef enum logic [1:0] {
        STEP_HOLD   = 2'b00,
        STEP_FIRST  = 2'b01,  // Round 10 has no InvMixColumns
        STEP_MIDDLE = 2'b10,
        STEP_LAST   = 2'b11   // Final AddRoundKey with K0
    } dec_step_t;

endpackage

// ==== hdl/aes_sbox.sv ====
`timescale 1ns/100ps

module aes_sbox #(
    parameter bit INVERSE = 1'b0
) (
    input  aes_data_pkg::byte_t in_byte,
    output aes_data_pkg::byte_t out_byte
);

    aes_data_pkg::byte_t inv_in;
    aes_data_pkg::byte_t inv_out;

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aes_data_pkg::byte_t xtime(input aes_data_pkg::byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_data_pkg::byte_t gf_mul(input aes_data_pkg::byte_t a,
                                                   input aes_data_pkg::byte_t b);
        aes_data_pkg::byte_t acc;
        aes_data_pkg::byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // a^254 is the inverse, and zero maps to zero as AES requires
    function automatic aes_data_pkg::byte_t gf_inv(input aes_data_pkg::byte_t a);
        aes_data_pkg::byte_t sq;
        aes_data_pkg::byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 0; i < 7; i++) begin
            sq  = gf_mul(sq, sq);   // a^2, a^4 ... a^128
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic aes_data_pkg::byte_t rotl(input aes_data_pkg::byte_t a, input int n);
        return aes_data_pkg::byte_t'({a, a} >> (8 - n));
    endfunction

    // Inverse S-box undoes the affine map before inverting
    always_comb begin
        if (INVERSE) begin
            inv_in = rotl(in_byte, 1) ^ rotl(in_byte, 3) ^ rotl(in_byte, 6) ^ 8'h05;
        end else begin
            inv_in = in_byte;
        end
    end

    assign inv_out = gf_inv(inv_in);

    assign out_byte = INVERSE ? inv_out
                              : (inv_out ^ rotl(inv_out, 1) ^ rotl(inv_out, 2)
                                 ^ rotl(inv_out, 3) ^ rotl(inv_out, 4) ^ 8'h63);

endmodule

// ==== hdl/round_counter.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module round_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_one,
    input  logic                  load_ten,
    input  logic                  count_up,
    input  logic                  count_down,
    output logic [`AES_RND_W-1:0] round,
    output logic                  at_ten,
    output logic                  at_zero
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round <= `AES_RND_W'd1;
        end else if (load_one) begin
            round <= `AES_RND_W'd1;          // Miss, start forward expansion
        end else if (load_ten) begin
            round <= `AES_RND_W'(`AES_NR);   // Hit, K10 already cached
        end else if (count_up) begin
            round <= round + 1'b1;
        end else if (count_down) begin
            round <= round - 1'b1;
        end
    end

    assign at_ten  = (round == `AES_RND_W'(`AES_NR));
    assign at_zero = (round == '0);

    // Controller must stop counting at both ends
    a_round_range: assert property (@(posedge clk) disable iff (!rst_n)
        round <= `AES_RND_W'(`AES_NR));

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load_one, load_ten, count_up, count_down}));

endmodule

// ==== hdl/dec_fsm.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module dec_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  aes_data_pkg::block_t    key_in,
    input  logic [`AES_RND_W-1:0]   round,
    input  logic                    at_ten,
    input  logic                    at_zero,
    input  aes_data_pkg::block_t    round_key,
    output aes_ctrl_pkg::kx_op_t    kx_op,
    output aes_data_pkg::block_t    load_key,
    output aes_ctrl_pkg::dec_step_t dec_step,
    output logic                    capture,
    output logic                    cnt_load_one,
    output logic                    cnt_load_ten,
    output logic                    cnt_up,
    output logic                    cnt_down,
    output logic                    valid_out,
    output logic                    busy
);

    aes_ctrl_pkg::fsm_state_t state;
    aes_ctrl_pkg::fsm_state_t next_state;
    aes_data_pkg::block_t     cache_key;   // Last key accepted
    aes_data_pkg::block_t     cache_k10;   // Its final round key
    logic                     cache_valid;
    logic                     key_hit;
    logic                     accept;

    assign key_hit = cache_valid && (cache_key == key_in);
    assign accept  = valid_in && (state == aes_ctrl_pkg::ST_IDLE);
    assign capture = accept;
    assign busy    = (state != aes_ctrl_pkg::ST_IDLE);

    assign load_key = key_hit ? cache_k10 : key_in;

    assign cnt_load_one = accept && !key_hit;
    assign cnt_load_ten = accept && key_hit;
    assign cnt_up       = (state == aes_ctrl_pkg::ST_K10_CALC) && !at_ten;
    assign cnt_down     = (state == aes_ctrl_pkg::ST_DECRYPT) && !at_zero;

    always_comb begin
        next_state = state;
        case (state)
            aes_ctrl_pkg::ST_IDLE:
                if (valid_in) next_state = key_hit ? aes_ctrl_pkg::ST_DECRYPT
                                                   : aes_ctrl_pkg::ST_K10_CALC;
            aes_ctrl_pkg::ST_K10_CALC:
                if (at_ten) next_state = aes_ctrl_pkg::ST_DECRYPT;
            aes_ctrl_pkg::ST_DECRYPT:
                if (at_zero) next_state = aes_ctrl_pkg::ST_IDLE;
            default: next_state = aes_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            aes_ctrl_pkg::ST_IDLE:     kx_op = aes_ctrl_pkg::KX_LOAD;
            aes_ctrl_pkg::ST_K10_CALC: kx_op = aes_ctrl_pkg::KX_FORWARD;
            aes_ctrl_pkg::ST_DECRYPT:  kx_op = aes_ctrl_pkg::KX_REVERSE;
            default:                   kx_op = aes_ctrl_pkg::KX_HOLD;
        endcase
    end

    // Round 10 is the first inverse round, round 0 the closing key add
    always_comb begin
        if (state != aes_ctrl_pkg::ST_DECRYPT) begin
            dec_step = aes_ctrl_pkg::STEP_HOLD;
        end else if (round == `AES_RND_W'(`AES_NR)) begin
            dec_step = aes_ctrl_pkg::STEP_FIRST;
        end else if (round == '0) begin
            dec_step = aes_ctrl_pkg::STEP_LAST;
        end else begin
            dec_step = aes_ctrl_pkg::STEP_MIDDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= aes_ctrl_pkg::ST_IDLE;
            valid_out   <= 1'b0;
            cache_valid <= 1'b0;
            cache_key   <= '0;
            cache_k10   <= '0;
        end else begin
            state     <= next_state;
            valid_out <= (state == aes_ctrl_pkg::ST_DECRYPT) && at_zero;
            if (accept) begin
                cache_key   <= key_in;
                cache_valid <= 1'b1;
            end
            // Key register holds K10 on entry to decryption
            if ((state == aes_ctrl_pkg::ST_DECRYPT) && at_ten) cache_k10 <= round_key;
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |=> !valid_out);

endmodule

// ==== hdl/key_expander.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module key_expander (
    input  logic                  clk,
    input  logic                  rst_n,
    input  aes_ctrl_pkg::kx_op_t  kx_op,
    input  aes_data_pkg::block_t  load_key,
    input  logic [`AES_RND_W-1:0] round,
    output aes_data_pkg::block_t  round_key
);

    aes_data_pkg::block_t key_q;
    aes_data_pkg::word_t  w0, w1, w2, w3;
    aes_data_pkg::word_t  sub_in;
    aes_data_pkg::word_t  rot_word;
    aes_data_pkg::word_t  sub_word;
    aes_data_pkg::word_t  temp;
    aes_data_pkg::block_t fwd_key;
    aes_data_pkg::block_t rev_key;

    function automatic aes_data_pkg::byte_t rcon(input logic [`AES_RND_W-1:0] r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    assign w0 = key_q[`AES_BLOCK_W-1 -: `AES_WORD_W];
    assign w1 = key_q[`AES_BLOCK_W-1-`AES_WORD_W -: `AES_WORD_W];
    assign w2 = key_q[`AES_BLOCK_W-1-2*`AES_WORD_W -: `AES_WORD_W];
    assign w3 = key_q[`AES_WORD_W-1:0];

    // Going back, the previous word 3 is w2 ^ w3 of the current key
    assign sub_in   = (kx_op == aes_ctrl_pkg::KX_REVERSE) ? (w2 ^ w3) : w3;
    assign rot_word = {sub_in[23:0], sub_in[31:24]};

    for (genvar i = 0; i < 4; i++) begin : g_sbox
        aes_sbox #(
            .INVERSE(1'b0)
        ) sbox_inst (
            .in_byte (rot_word[31-8*i -: 8]),
            .out_byte(sub_word[31-8*i -: 8])
        );
    end

    assign temp = sub_word ^ {rcon(round), 24'h0};

    always_comb begin
        fwd_key[127:96] = w0 ^ temp;   // Chain through the new words
        fwd_key[95:64]  = w1 ^ fwd_key[127:96];
        fwd_key[63:32]  = w2 ^ fwd_key[95:64];
        fwd_key[31:0]   = w3 ^ fwd_key[63:32];
    end

    assign rev_key = {w0 ^ temp, w1 ^ w0, w2 ^ w1, w3 ^ w2};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q <= '0;
        end else begin
            case (kx_op)
                aes_ctrl_pkg::KX_LOAD:    key_q <= load_key;
                aes_ctrl_pkg::KX_FORWARD: key_q <= fwd_key;
                aes_ctrl_pkg::KX_REVERSE: key_q <= rev_key;
                default:                  key_q <= key_q;
            endcase
        end
    end

    assign round_key = key_q;

endmodule

// ==== hdl/inv_round.sv ====
`timescale 1ns/100ps

module inv_round (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    capture,
    input  aes_data_pkg::block_t    cipher_in,
    input  aes_data_pkg::block_t    round_key,
    input  aes_ctrl_pkg::dec_step_t dec_step,
    output aes_data_pkg::block_t    state_out
);

    aes_data_pkg::block_t state_q;
    aes_data_pkg::block_t ark;       // After AddRoundKey
    aes_data_pkg::block_t mixed;
    aes_data_pkg::block_t shifted;
    aes_data_pkg::block_t subbed;

    function automatic aes_data_pkg::byte_t xtime(input aes_data_pkg::byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Small constant multiply for the InvMixColumns coefficients 9, b, d, e
    function automatic aes_data_pkg::byte_t gf_mul4(input aes_data_pkg::byte_t a,
                                                    input logic [3:0] c);
        aes_data_pkg::byte_t acc;
        aes_data_pkg::byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 4; i++) begin
            if (c[i]) acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    function automatic aes_data_pkg::word_t inv_mix_col(input aes_data_pkg::word_t col);
        aes_data_pkg::byte_t a0, a1, a2, a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {gf_mul4(a0, 4'he) ^ gf_mul4(a1, 4'hb) ^ gf_mul4(a2, 4'hd) ^ gf_mul4(a3, 4'h9),
                gf_mul4(a0, 4'h9) ^ gf_mul4(a1, 4'he) ^ gf_mul4(a2, 4'hb) ^ gf_mul4(a3, 4'hd),
                gf_mul4(a0, 4'hd) ^ gf_mul4(a1, 4'h9) ^ gf_mul4(a2, 4'he) ^ gf_mul4(a3, 4'hb),
                gf_mul4(a0, 4'hb) ^ gf_mul4(a1, 4'hd) ^ gf_mul4(a2, 4'h9) ^ gf_mul4(a3, 4'he)};
    endfunction

    // Row r rotates right by r, byte index is 4*column + row
    function automatic aes_data_pkg::block_t inv_shift_rows(input aes_data_pkg::block_t s);
        aes_data_pkg::block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[127-8*(4*c+r) -: 8] = s[127-8*(4*((c+4-r)%4)+r) -: 8];
            end
        end
        return o;
    endfunction

    assign ark = state_q ^ round_key;

    for (genvar c = 0; c < 4; c++) begin : g_mix
        assign mixed[127-32*c -: 32] = inv_mix_col(ark[127-32*c -: 32]);
    end

    assign shifted = inv_shift_rows((dec_step == aes_ctrl_pkg::STEP_MIDDLE) ? mixed : ark);

    for (genvar i = 0; i < 16; i++) begin : g_sbox
        aes_sbox #(
            .INVERSE(1'b1)
        ) sbox_inst (
            .in_byte (shifted[127-8*i -: 8]),
            .out_byte(subbed[127-8*i -: 8])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (capture) begin
            state_q <= cipher_in;
        end else begin
            case (dec_step)
                aes_ctrl_pkg::STEP_FIRST,
                aes_ctrl_pkg::STEP_MIDDLE: state_q <= subbed;
                aes_ctrl_pkg::STEP_LAST:   state_q <= ark;   // Plaintext
                default:                   state_q <= state_q;
            endcase
        end
    end

    assign state_out = state_q;

    // A new block may only load while the datapath is idle
    a_capture_idle: assert property (@(posedge clk) disable iff (!rst_n)
        capture |-> (dec_step == aes_ctrl_pkg::STEP_HOLD));

endmodule

// ==== hdl/aes_dec_top.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_dec_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  aes_data_pkg::block_t key_in,
    input  aes_data_pkg::block_t cipher_in,
    output logic                 valid_out,
    output logic                 busy,
    output aes_data_pkg::block_t plain_out
);

    aes_ctrl_pkg::kx_op_t    kx_op;
    aes_ctrl_pkg::dec_step_t dec_step;
    aes_data_pkg::block_t    load_key;
    aes_data_pkg::block_t    round_key;
    logic [`AES_RND_W-1:0]   round;
    logic                    at_ten;
    logic                    at_zero;
    logic                    capture;
    logic                    cnt_load_one;
    logic                    cnt_load_ten;
    logic                    cnt_up;
    logic                    cnt_down;

    dec_fsm dec_fsm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .key_in      (key_in),
        .round       (round),
        .at_ten      (at_ten),
        .at_zero     (at_zero),
        .round_key   (round_key),
        .kx_op       (kx_op),
        .load_key    (load_key),
        .dec_step    (dec_step),
        .capture     (capture),
        .cnt_load_one(cnt_load_one),
        .cnt_load_ten(cnt_load_ten),
        .cnt_up      (cnt_up),
        .cnt_down    (cnt_down),
        .valid_out   (valid_out),
        .busy        (busy)
    );

    round_counter round_counter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_one  (cnt_load_one),
        .load_ten  (cnt_load_ten),
        .count_up  (cnt_up),
        .count_down(cnt_down),
        .round     (round),
        .at_ten    (at_ten),
        .at_zero   (at_zero)
    );

    key_expander key_expander_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .kx_op    (kx_op),
        .load_key (load_key),
        .round    (round),
        .round_key(round_key)
    );

    inv_round inv_round_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .cipher_in(cipher_in),
        .round_key(round_key),
        .dec_step (dec_step),
        .state_out(plain_out)
    );

endmodule

// ==== verif/aes_dec_tb.sv ====
`timescale 1ns/100ps

module aes_dec_tb;

    localparam int NUM_TESTS  = 5;
    localparam int MAX_WAIT   = 25;    // Longest expected latency is 21
    localparam int POKE_CYCLE = 4;     // Cycle of the strobe sent while busy
    // Five tests of at most 25 cycles plus reset, with generous margin
    localparam int MAX_CYCLES = 300;

    typedef struct packed {
        aes_data_pkg::block_t key;
        aes_data_pkg::block_t cipher;
        aes_data_pkg::block_t plain;
        logic [7:0]           latency;   // 11 on a cache hit, 21 on a miss
    } vector_t;

    logic                 clk;
    logic                 rst_n;
    logic                 valid_in;
    aes_data_pkg::block_t key_in;
    aes_data_pkg::block_t cipher_in;
    logic                 valid_out;
    logic                 busy;
    aes_data_pkg::block_t plain_out;

    vector_t vectors [NUM_TESTS];
    int      test_errors;
    int      passed;
    int      failed;
    int      cycle_count = 0;

    aes_dec_top aes_dec_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_in (valid_in),
        .key_in   (key_in),
        .cipher_in(cipher_in),
        .valid_out(valid_out),
        .busy     (busy),
        .plain_out(plain_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // FIPS-197 Appendix B and C.1 vectors
    task automatic load_vectors();
        vectors[0] = '{key:     128'h2b7e151628aed2a6abf7158809cf4f3c,
                       cipher:  128'h3925841d02dc09fbdc118597196a0b32,
                       plain:   128'h3243f6a8885a308d313198a2e0370734,
                       latency: 8'd21};
        vectors[1] = vectors[0];
        vectors[1].latency = 8'd11;   // Same key, cached K10
        vectors[2] = '{key:     128'h000102030405060708090a0b0c0d0e0f,
                       cipher:  128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                       plain:   128'h00112233445566778899aabbccddeeff,
                       latency: 8'd21};
        vectors[3] = vectors[2];
        vectors[3].latency = 8'd11;
        vectors[4] = vectors[0];      // Cache only keeps the last key
    endtask

    task automatic report_mismatch(input string name,
                                   input aes_data_pkg::block_t expected,
                                   input aes_data_pkg::block_t actual);
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic log_result(input string label);
        if (test_errors == 0) begin
            $display("%s: PASS", label);
            passed++;
        end else begin
            $display("%s: FAIL with %0d errors", label, test_errors);
            failed++;
        end
    endtask

    task automatic run_vector(input int idx);
        vector_t v;
        int      cycles;
        v = vectors[idx];
        test_errors = 0;
        cycles = 0;
        key_in    = v.key;
        cipher_in = v.cipher;
        valid_in  = 1'b1;
        @(negedge clk);                // Accept edge has passed
        valid_in = 1'b0;
        if (busy !== 1'b1) report_mismatch("busy", 1, busy);
        while (cycles < MAX_WAIT && valid_out !== 1'b1) begin
            @(negedge clk);
            cycles++;
            valid_in = (cycles == POKE_CYCLE);
            if (cycles == POKE_CYCLE) begin
                cipher_in = ~v.cipher;   // Must not reach the datapath
            end
        end
        valid_in = 1'b0;
        if (valid_out !== 1'b1) begin
            $display("Test %0d: valid_out did not rise within %0d cycles", idx + 1, MAX_WAIT);
            test_errors++;
        end else begin
            if (cycles != v.latency) report_mismatch("valid_out latency", v.latency, cycles);
            if (plain_out !== v.plain) report_mismatch("plain_out", v.plain, plain_out);
            if (busy !== 1'b0) report_mismatch("busy", 0, busy);
            @(negedge clk);
            if (valid_out !== 1'b0) report_mismatch("valid_out", 0, valid_out);
            repeat (2) @(negedge clk);
            // Result stays until the next accept
            if (plain_out !== v.plain) report_mismatch("plain_out", v.plain, plain_out);
            if (valid_out !== 1'b0) report_mismatch("valid_out", 0, valid_out);
        end
        log_result($sformatf("Test %0d (%s, latency %0d)", idx + 1,
                             (v.latency == 8'd11) ? "hit" : "miss", cycles));
    endtask

    initial begin
        rst_n       = 1'b0;
        valid_in    = 1'b0;
        key_in      = '0;
        cipher_in   = '0;
        passed      = 0;
        failed      = 0;
        test_errors = 0;
        load_vectors();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle outputs before the first strobe
        if (valid_out !== 1'b0) report_mismatch("valid_out", 0, valid_out);
        if (busy !== 1'b0) report_mismatch("busy", 0, busy);
        if (plain_out !== '0) report_mismatch("plain_out", 0, plain_out);
        log_result("Reset check");

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_vector(i);
        end

        $display("Checks done: %0d passed, %0d failed, %0d cycles",
                 passed, failed, cycle_count);
        if (failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/aes_data_pkg.sv
hdl/aes_ctrl_pkg.sv
hdl/aes_sbox.sv
hdl/round_counter.sv
hdl/dec_fsm.sv
hdl/key_expander.sv
hdl/inv_round.sv
hdl/aes_dec_top.sv
verif/aes_dec_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = aes_dec_tb
FILELIST = vlog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = sim passed

SRCS    := $(shell grep -E '\.s?v$$' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
